// File: source/merge_data_pkg.sv
// --------------------
// widths and window constants, merge type codes
// and packed structs of the merge-data engine
// --------------------
`default_nettype none

package merge_data_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int vertex_id_width = 16;
    localparam int data_width      = 32;
    localparam int offset_width    = 16;

    // --------------------
    // configuration window
    // --------------------
    // first word offset owned by this engine
    localparam logic [offset_width-1:0] cfg_window_base = 16'd32;
    // positions 0 and 1 carry fields, 2 and 3 reserved
    localparam int cfg_window_words = 4;

    // --------------------
    // lane buffer sizing
    // --------------------
    localparam int lane_depth     = 4;
    // depth is a power of two, pointers wrap on their own
    localparam int lane_ptr_width = 2;

    // --------------------
    // merge type codes
    // --------------------
    // primary lane data unchanged
    localparam logic [1:0] merge_pass = 2'd0;
    // wrapping sum
    localparam logic [1:0] merge_sum  = 2'd1;
    // unsigned minimum
    localparam logic [1:0] merge_min  = 2'd2;
    // unsigned maximum
    localparam logic [1:0] merge_max  = 2'd3;

    // --------------------
    // structs
    // --------------------
    // memory response word, no back-pressure
    typedef struct packed {
        logic                    valid;
        logic [offset_width-1:0] offset;
        logic [data_width-1:0]   data;
    } memory_response_t;

    // vertex packet, valid/ready travel beside it
    typedef struct packed {
        logic [vertex_id_width-1:0] vertex_id;
        logic [data_width-1:0]      data;
    } vertex_packet_t;

    // loaded merge configuration
    typedef struct packed {
        // bit 0 lane a, bit 1 lane b
        logic [1:0] merge_mask;
        logic [1:0] merge_type;
    } merge_config_t;

endpackage

`default_nettype wire

// File: source/merge_config_loader.sv
// --------------------
// memory response window filter and
// merge configuration sequence
// --------------------
`timescale 1ns/1ps
`default_nettype none

module merge_config_loader (
    input  wire logic                             ap_clk,
    input  wire logic                             arst_n,
    input  wire merge_data_pkg::memory_response_t response_in,
    output merge_data_pkg::merge_config_t         cfg,
    output logic                                  configured
);

    // --------------------
    // signals
    // --------------------
    // registered response word
    merge_data_pkg::memory_response_t response_q;

    // window test on the registered word
    logic in_window;
    logic hit;
    logic seq_start;
    logic seq_advance;

    // one-hot position of the last accepted word
    logic [merge_data_pkg::cfg_window_words-1:0] seq_q;

    // fields collected while the sequence runs
    logic [1:0] mask_stage_q;
    logic [1:0] type_stage_q;

    // --------------------
    // input register
    // --------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            response_q <= '0;
        end else begin
            response_q <= response_in;
        end
    end

    // --------------------
    // window filter
    // --------------------
    assign in_window = (response_q.offset >= merge_data_pkg::cfg_window_base) &&
                       (response_q.offset < (merge_data_pkg::cfg_window_base +
                                             merge_data_pkg::cfg_window_words));
    assign hit = response_q.valid && in_window;

    // base offset opens a sequence only when idle
    assign seq_start = hit && (response_q.offset == merge_data_pkg::cfg_window_base) &&
                       (seq_q == '0);
    // any in-window word moves a running sequence on
    assign seq_advance = hit && (seq_q != '0);

    // --------------------
    // sequence and outputs
    // --------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            seq_q      <= '0;
            cfg        <= '0;
            configured <= 1'b0;
        end else begin
            if (seq_q[merge_data_pkg::cfg_window_words-1]) begin
                // fourth word taken last cycle, publish
                seq_q      <= '0;
                cfg        <= '{merge_mask: mask_stage_q, merge_type: type_stage_q};
                configured <= 1'b1;
            end else if (seq_start) begin
                seq_q <= merge_data_pkg::cfg_window_words'(1);
            end else if (seq_advance) begin
                seq_q <= seq_q << 1;
            end
        end
    end

    // field capture
    // position 0 is the mask, position 1 the type, rest ignored
    always_ff @(posedge ap_clk) begin
        if (seq_start) begin
            mask_stage_q <= response_q.data[1:0];
        end
        if (seq_advance && seq_q[0]) begin
            type_stage_q <= response_q.data[1:0];
        end
    end

    // --------------------
    // assertions
    // --------------------
    // at most one position live at a time
    assert property (@(posedge ap_clk) disable iff (!arst_n) $onehot0(seq_q))
        else $error("config loader sequence not one-hot: %b", seq_q);

endmodule

`default_nettype wire

// File: source/merge_lane_buffer.sv
// --------------------
// register FIFO for one lane of vertex packets
// --------------------
`timescale 1ns/1ps
`default_nettype none

module merge_lane_buffer (
    input  wire logic                           ap_clk,
    input  wire logic                           arst_n,
    input  wire logic                           in_valid,
    output logic                                in_ready,
    input  wire merge_data_pkg::vertex_packet_t in_packet,
    output logic                                head_valid,
    output merge_data_pkg::vertex_packet_t      head_packet,
    input  wire logic                           pop
);

    // --------------------
    // storage and pointers
    // --------------------
    merge_data_pkg::vertex_packet_t mem_q [merge_data_pkg::lane_depth];

    logic [merge_data_pkg::lane_ptr_width-1:0] wr_ptr_q;
    logic [merge_data_pkg::lane_ptr_width-1:0] rd_ptr_q;
    // one extra bit to hold lane_depth
    logic [merge_data_pkg::lane_ptr_width:0]   count_q;

    logic push;

    // ready only looks at fill level, never at valid or pop
    assign in_ready = (count_q != merge_data_pkg::lane_depth);
    assign push     = in_valid && in_ready;

    // head straight from storage
    assign head_valid  = (count_q != '0);
    assign head_packet = mem_q[rd_ptr_q];

    // --------------------
    // pointer and count update
    // --------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keep the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push && pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // data write
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_packet;
        end
    end

    // --------------------
    // assertions
    // --------------------
    // full and no pop, nothing may get in
    assert property (@(posedge ap_clk) disable iff (!arst_n)
        (count_q == merge_data_pkg::lane_depth) && !pop |=>
            (count_q == merge_data_pkg::lane_depth))
        else $error("lane buffer overflow");

    // combiner pops only a present head
    assert property (@(posedge ap_clk) disable iff (!arst_n) pop |-> head_valid)
        else $error("lane buffer popped while empty");

endmodule

`default_nettype wire

// File: source/merge_data_combiner.sv
// --------------------
// merges enabled lane heads into one
// registered output packet stream
// --------------------
`timescale 1ns/1ps
`default_nettype none

module merge_data_combiner (
    input  wire logic                           ap_clk,
    input  wire logic                           arst_n,
    input  wire merge_data_pkg::merge_config_t  cfg,
    input  wire logic                           configured,
    input  wire logic                           a_valid,
    input  wire merge_data_pkg::vertex_packet_t a_packet,
    output logic                                a_pop,
    input  wire logic                           b_valid,
    input  wire merge_data_pkg::vertex_packet_t b_packet,
    output logic                                b_pop,
    output logic                                merged_valid,
    input  wire logic                           merged_ready,
    output merge_data_pkg::vertex_packet_t      merged_out
);

    // --------------------
    // merge of two data values
    // --------------------
    function automatic logic [merge_data_pkg::data_width-1:0] merge_values(
        input logic [1:0]                            merge_type,
        input logic [merge_data_pkg::data_width-1:0] a_data,
        input logic [merge_data_pkg::data_width-1:0] b_data
    );
        logic [merge_data_pkg::data_width-1:0] result;
        case (merge_type)
            merge_data_pkg::merge_sum: result = a_data + b_data;
            merge_data_pkg::merge_min: result = (a_data < b_data) ? a_data : b_data;
            merge_data_pkg::merge_max: result = (a_data > b_data) ? a_data : b_data;
            // pass keeps the primary lane
            default:                   result = a_data;
        endcase
        return result;
    endfunction

    // --------------------
    // signals
    // --------------------
    logic need_a;
    logic need_b;
    logic heads_ready;
    logic out_free;
    logic fire;

    merge_data_pkg::vertex_packet_t merged_next;

    // --------------------
    // issue decision
    // --------------------
    assign need_a = cfg.merge_mask[0];
    assign need_b = cfg.merge_mask[1];

    // all enabled heads present, empty mask never merges
    assign heads_ready = (need_a || need_b) && (!need_a || a_valid) && (!need_b || b_valid);
    // output slot empty or drained this edge
    assign out_free    = !merged_valid || merged_ready;
    assign fire        = configured && heads_ready && out_free;

    // pop only alongside the load of the output register
    assign a_pop = fire && need_a;
    assign b_pop = fire && need_b;

    // --------------------
    // packet select
    // --------------------
    always_comb begin
        merged_next = a_packet;
        case (cfg.merge_mask)
            2'b10: begin
                // lane b alone passes through
                merged_next = b_packet;
            end
            2'b11: begin
                // lane a id, merged data
                merged_next.vertex_id = a_packet.vertex_id;
                merged_next.data      = merge_values(cfg.merge_type, a_packet.data,
                                                     b_packet.data);
            end
            default: begin
                merged_next = a_packet;
            end
        endcase
    end

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            merged_valid <= 1'b0;
        end else begin
            if (fire) begin
                merged_valid <= 1'b1;
            end else if (merged_ready) begin
                merged_valid <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge ap_clk) begin
        if (fire) begin
            merged_out <= merged_next;
        end
    end

    // --------------------
    // assertions
    // --------------------
    // stalled output holds its packet
    assert property (@(posedge ap_clk) disable iff (!arst_n)
        merged_valid && !merged_ready |=> merged_valid && $stable(merged_out))
        else $error("merged output changed while stalled");

endmodule

`default_nettype wire

// File: source/engine_merge_data.sv
// --------------------
// merge-data engine top, loader plus
// two lane buffers and the combiner
// --------------------
`timescale 1ns/1ps
`default_nettype none

module engine_merge_data (
    input  wire logic                             ap_clk,
    input  wire logic                             arst_n,
    input  wire merge_data_pkg::memory_response_t response_in,
    // lane a
    input  wire logic                             lane_a_valid,
    output logic                                  lane_a_ready,
    input  wire merge_data_pkg::vertex_packet_t   lane_a_in,
    // lane b
    input  wire logic                             lane_b_valid,
    output logic                                  lane_b_ready,
    input  wire merge_data_pkg::vertex_packet_t   lane_b_in,
    // merged stream
    output logic                                  merged_valid,
    input  wire logic                             merged_ready,
    output merge_data_pkg::vertex_packet_t        merged_out,
    output logic                                  configured
);

    // --------------------
    // internal wires
    // --------------------
    merge_data_pkg::merge_config_t  cfg;

    logic                           head_a_valid;
    merge_data_pkg::vertex_packet_t head_a_packet;
    logic                           pop_a;

    logic                           head_b_valid;
    merge_data_pkg::vertex_packet_t head_b_packet;
    logic                           pop_b;

    // configuration from the response stream
    merge_config_loader u_config_loader (
        .ap_clk      (ap_clk),
        .arst_n      (arst_n),
        .response_in (response_in),
        .cfg         (cfg),
        .configured  (configured)
    );

    // lane a buffer
    merge_lane_buffer u_lane_a (
        .ap_clk      (ap_clk),
        .arst_n      (arst_n),
        .in_valid    (lane_a_valid),
        .in_ready    (lane_a_ready),
        .in_packet   (lane_a_in),
        .head_valid  (head_a_valid),
        .head_packet (head_a_packet),
        .pop         (pop_a)
    );

    // lane b buffer
    merge_lane_buffer u_lane_b (
        .ap_clk      (ap_clk),
        .arst_n      (arst_n),
        .in_valid    (lane_b_valid),
        .in_ready    (lane_b_ready),
        .in_packet   (lane_b_in),
        .head_valid  (head_b_valid),
        .head_packet (head_b_packet),
        .pop         (pop_b)
    );

    // head merge and output register
    merge_data_combiner u_combiner (
        .ap_clk       (ap_clk),
        .arst_n       (arst_n),
        .cfg          (cfg),
        .configured   (configured),
        .a_valid      (head_a_valid),
        .a_packet     (head_a_packet),
        .a_pop        (pop_a),
        .b_valid      (head_b_valid),
        .b_packet     (head_b_packet),
        .b_pop        (pop_b),
        .merged_valid (merged_valid),
        .merged_ready (merged_ready),
        .merged_out   (merged_out)
    );

endmodule

`default_nettype wire

// File: testbench/tb_engine_merge_data.sv
// --------------------
// testbench for the merge-data engine with stimulus, reference merge,
// output checker and watchdog
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_engine_merge_data;

    // --------------------
    // run length
    // --------------------
    // lane packets over all tests, see the sequence below
    localparam int total_packets   = 172;
    localparam int total_outputs   = 90;
    localparam int watchdog_cycles = total_packets * 20 + 500;

    // --------------------
    // DUT signals
    // --------------------
    logic                             ap_clk;
    logic                             arst_n;
    merge_data_pkg::memory_response_t response_in;
    logic                             lane_a_valid;
    logic                             lane_a_ready;
    merge_data_pkg::vertex_packet_t   lane_a_in;
    logic                             lane_b_valid;
    logic                             lane_b_ready;
    merge_data_pkg::vertex_packet_t   lane_b_in;
    logic                             merged_valid;
    logic                             merged_ready;
    merge_data_pkg::vertex_packet_t   merged_out;
    logic                             configured;

    // --------------------
    // testbench state
    // --------------------
    int seed;
    int ready_pct;
    int value_errors;
    int other_errors;
    int out_count;
    int next_id_a;
    int next_id_b;

    // configuration the checker expects
    logic [1:0] cur_mask;
    logic [1:0] cur_type;

    // accepted lane packets in order
    merge_data_pkg::vertex_packet_t queue_a[$];
    merge_data_pkg::vertex_packet_t queue_b[$];

    // stall tracking
    logic                           hold_pending;
    merge_data_pkg::vertex_packet_t held_pkt;

    engine_merge_data UUT (
        .ap_clk       (ap_clk),
        .arst_n       (arst_n),
        .response_in  (response_in),
        .lane_a_valid (lane_a_valid),
        .lane_a_ready (lane_a_ready),
        .lane_a_in    (lane_a_in),
        .lane_b_valid (lane_b_valid),
        .lane_b_ready (lane_b_ready),
        .lane_b_in    (lane_b_in),
        .merged_valid (merged_valid),
        .merged_ready (merged_ready),
        .merged_out   (merged_out),
        .configured   (configured)
    );

    // 8 ns period
    always #4 ap_clk = ~ap_clk;

    // random output back-pressure
    always @(posedge ap_clk) begin
        merged_ready <= (({$random(seed)} % 100) < ready_pct);
    end

    // --------------------
    // reference merge
    // --------------------
    function automatic merge_data_pkg::vertex_packet_t reference_merge(
        input logic [1:0]                     mask,
        input logic [1:0]                     mtype,
        input merge_data_pkg::vertex_packet_t pa,
        input merge_data_pkg::vertex_packet_t pb
    );
        merge_data_pkg::vertex_packet_t r;
        r = pa;
        // single lane passes whole packet
        if (mask == 2'b10) begin
            r = pb;
        end else if (mask == 2'b11) begin
            // id from lane a always
            if (mtype == merge_data_pkg::merge_sum) begin
                r.data = pa.data + pb.data;
            end else if (mtype == merge_data_pkg::merge_min) begin
                r.data = (pa.data <= pb.data) ? pa.data : pb.data;
            end else if (mtype == merge_data_pkg::merge_max) begin
                r.data = (pa.data >= pb.data) ? pa.data : pb.data;
            end
        end
        return r;
    endfunction

    // --------------------
    // monitor and checker
    // --------------------
    always @(posedge ap_clk) begin
        merge_data_pkg::vertex_packet_t pa;
        merge_data_pkg::vertex_packet_t pb;
        merge_data_pkg::vertex_packet_t exp;
        if (arst_n) begin
            if (lane_a_valid && lane_a_ready) begin
                queue_a.push_back(lane_a_in);
            end
            if (lane_b_valid && lane_b_ready) begin
                queue_b.push_back(lane_b_in);
            end
            if (merged_valid && !configured) begin
                $display("merged output seen before configuration");
                other_errors++;
            end
            // stalled packet must stay put
            if (hold_pending) begin
                if (!merged_valid) begin
                    $display("merged_valid dropped while the output was stalled");
                    other_errors++;
                end else if (merged_out !== held_pkt) begin
                    $display("ERROR merged_out expected %h actual %h", held_pkt, merged_out);
                    value_errors++;
                end
            end
            hold_pending = merged_valid && !merged_ready;
            held_pkt     = merged_out;
            if (merged_valid && merged_ready) begin
                out_count++;
                if ((cur_mask[0] && queue_a.size() == 0) ||
                    (cur_mask[1] && queue_b.size() == 0)) begin
                    $display("output packet with no matching lane input queued");
                    other_errors++;
                end else begin
                    pa  = cur_mask[0] ? queue_a.pop_front() : '0;
                    pb  = cur_mask[1] ? queue_b.pop_front() : '0;
                    exp = reference_merge(cur_mask, cur_type, pa, pb);
                    if (merged_out.vertex_id !== exp.vertex_id) begin
                        $display("ERROR merged_out.vertex_id expected %h actual %h",
                                 exp.vertex_id, merged_out.vertex_id);
                        value_errors++;
                    end
                    if (merged_out.data !== exp.data) begin
                        $display("ERROR merged_out.data expected %h actual %h",
                                 exp.data, merged_out.data);
                        value_errors++;
                    end
                end
            end
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------
    // offers count packets on one lane with random idle cycles
    task automatic send_lane(input bit use_b, input int count, input int idle_pct);
        int                             sent;
        logic                           offered;
        logic                           taken;
        merge_data_pkg::vertex_packet_t pkt;
        sent = 0;
        while (sent < count) begin
            @(posedge ap_clk);
            offered = use_b ? lane_b_valid : lane_a_valid;
            taken   = use_b ? (lane_b_valid && lane_b_ready) : (lane_a_valid && lane_a_ready);
            if (taken) begin
                sent++;
            end
            if (taken || !offered) begin
                if (sent < count && ({$random(seed)} % 100) >= idle_pct) begin
                    pkt.data = $random(seed);
                    if (use_b) begin
                        pkt.vertex_id = next_id_b[15:0];
                        next_id_b++;
                        lane_b_in    <= pkt;
                        lane_b_valid <= 1'b1;
                    end else begin
                        pkt.vertex_id = next_id_a[15:0];
                        next_id_a++;
                        lane_a_in    <= pkt;
                        lane_a_valid <= 1'b1;
                    end
                end else if (use_b) begin
                    lane_b_valid <= 1'b0;
                end else begin
                    lane_a_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic put_response(input logic [15:0] offset, input logic [31:0] data);
        @(posedge ap_clk);
        response_in <= '{valid: 1'b1, offset: offset, data: data};
    endtask

    task automatic idle_response();
        @(posedge ap_clk);
        response_in.valid <= 1'b0;
    endtask

    // full window sequence, optional noise words in the middle
    task automatic load_config(input logic [1:0] mask, input logic [1:0] mtype,
                               input bit noisy);
        logic [31:0] word;
        cur_mask = mask;
        cur_type = mtype;
        word = $random(seed);
        put_response(merge_data_pkg::cfg_window_base, {word[31:2], mask});
        if (noisy) begin
            put_response(merge_data_pkg::cfg_window_base + 16'd9, $random(seed));
            idle_response();
            put_response(merge_data_pkg::cfg_window_base - 16'd1, $random(seed));
        end
        word = $random(seed);
        put_response(merge_data_pkg::cfg_window_base + 16'd1, {word[31:2], mtype});
        put_response(merge_data_pkg::cfg_window_base + 16'd2, $random(seed));
        put_response(merge_data_pkg::cfg_window_base + 16'd3, $random(seed));
        idle_response();
        // two cycle latency after the last word, plus margin
        repeat (3) @(posedge ap_clk);
        if (configured !== 1'b1) begin
            $display("configured did not rise after the window was loaded");
            other_errors++;
        end
    endtask

    // nothing left in flight for the enabled lanes
    task automatic wait_drain();
        while (!(queue_a.size() == 0 && (!cur_mask[1] || queue_b.size() == 0) &&
                 !merged_valid)) begin
            @(posedge ap_clk);
        end
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial begin
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("watchdog expired, the run did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        seed          = 32'h7ce643d5;
        ap_clk        = 1'b0;
        arst_n        = 1'b0;
        response_in   = '0;
        lane_a_valid  = 1'b0;
        lane_a_in     = '0;
        lane_b_valid  = 1'b0;
        lane_b_in     = '0;
        merged_ready  = 1'b1;
        ready_pct     = 100;
        value_errors  = 0;
        other_errors  = 0;
        out_count     = 0;
        next_id_a     = 16'h1000;
        next_id_b     = 16'h2000;
        cur_mask      = 2'b00;
        cur_type      = 2'b00;
        hold_pending  = 1'b0;
        held_pkt      = '0;
        repeat (3) @(posedge ap_clk);
        arst_n <= 1'b1;
        @(posedge ap_clk);
        if (!lane_a_ready || !lane_b_ready || configured || merged_valid) begin
            $display("outputs not at their reset values after reset");
            other_errors++;
        end

        // unconfigured, lanes fill and stall
        fork
            send_lane(1'b0, 6, 0);
            send_lane(1'b1, 6, 0);
        join_none
        repeat (20) @(posedge ap_clk);
        if (lane_a_ready !== 1'b0) begin
            $display("ERROR lane_a_ready expected %h actual %h", 1'b0, lane_a_ready);
            value_errors++;
        end
        if (lane_b_ready !== 1'b0) begin
            $display("ERROR lane_b_ready expected %h actual %h", 1'b0, lane_b_ready);
            value_errors++;
        end
        if (queue_a.size() != merge_data_pkg::lane_depth ||
            queue_b.size() != merge_data_pkg::lane_depth) begin
            $display("lanes took %0d and %0d packets before stalling, expected %0d each",
                     queue_a.size(), queue_b.size(), merge_data_pkg::lane_depth);
            other_errors++;
        end

        // stray words then a noisy sum load
        put_response(16'd0, 32'h0000_0003);
        put_response(merge_data_pkg::cfg_window_base + 16'd2, 32'h0000_0002);
        put_response(merge_data_pkg::cfg_window_base + 16'd4, 32'h0000_0001);
        put_response(16'hffff, 32'hffff_ffff);
        idle_response();
        load_config(2'b11, merge_data_pkg::merge_sum, 1'b1);
        wait fork;
        wait_drain();

        // pass, min and max on both lanes
        ready_pct = 70;
        load_config(2'b11, merge_data_pkg::merge_pass, 1'b0);
        fork
            send_lane(1'b0, 12, 20);
            send_lane(1'b1, 12, 20);
        join
        wait_drain();
        load_config(2'b11, merge_data_pkg::merge_min, 1'b0);
        fork
            send_lane(1'b0, 12, 20);
            send_lane(1'b1, 12, 20);
        join
        wait_drain();
        load_config(2'b11, merge_data_pkg::merge_max, 1'b0);
        fork
            send_lane(1'b0, 12, 20);
            send_lane(1'b1, 12, 20);
        join
        wait_drain();

        // lane a alone, lane b left to fill
        ready_pct = 100;
        load_config(2'b01, merge_data_pkg::merge_sum, 1'b0);
        fork
            send_lane(1'b0, 8, 10);
            send_lane(1'b1, 4, 0);
        join
        wait_drain();
        @(posedge ap_clk);
        if (lane_b_ready !== 1'b0) begin
            $display("ERROR lane_b_ready expected %h actual %h", 1'b0, lane_b_ready);
            value_errors++;
        end

        // heavy back-pressure, stale lane b heads pair first
        ready_pct = 50;
        load_config(2'b11, merge_data_pkg::merge_max, 1'b0);
        fork
            send_lane(1'b0, 40, 40);
            send_lane(1'b1, 36, 40);
        join
        wait_drain();
        repeat (5) @(posedge ap_clk);

        if (queue_a.size() != 0 || queue_b.size() != 0) begin
            $display("lane queues not empty at the end, lane a %0d lane b %0d left",
                     queue_a.size(), queue_b.size());
            other_errors++;
        end
        if (out_count != total_outputs) begin
            $display("wrong number of merged packets, expected %0d got %0d",
                     total_outputs, out_count);
            other_errors++;
        end
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/merge_data_pkg.sv
source/merge_config_loader.sv
source/merge_lane_buffer.sv
source/merge_data_combiner.sv
source/engine_merge_data.sv
testbench/tb_engine_merge_data.sv

// File: Bender.yml
package:
  name: engine_merge_data

sources:
  - source/merge_data_pkg.sv
  - source/merge_config_loader.sv
  - source/merge_lane_buffer.sv
  - source/merge_data_combiner.sv
  - source/engine_merge_data.sv
  - target: simulation
    files:
      - testbench/tb_engine_merge_data.sv
